// ==== stepper_pkg.sv ====
package stepper_pkg;

  // Host words are little-endian on the wire
  localparam int unsigned word_w = 32;

  // Header opcodes live in bits 31 to 24
  localparam logic [7:0] op_move      = 8'h01;  // Header then duration word
  localparam logic [7:0] op_divisor   = 8'h03;  // Step clock divisor, bits 23..0
  localparam logic [7:0] op_microstep = 8'h04;  // 1, 2, 4 or 8 in bits 3..0

  // Microstep code, also the shift applied to the phase increment
  typedef enum logic [1:0] {
    ustep_full    = 2'd0,
    ustep_half    = 2'd1,
    ustep_quarter = 2'd2,
    ustep_eighth  = 2'd3
  } ustep_t;

  // 32 positions per electrical cycle
  // 4 full steps of 8 microsteps each
  localparam int unsigned phase_idx_w = 5;

  // Register values after reset
  localparam int unsigned default_divisor  = 50000;
  localparam logic [31:0] default_duration = 32'h005fffff;

endpackage

// ==== spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
  input  logic       CLK,
  input  logic       arst_n,
  input  logic       sck,
  input  logic       ssel,
  input  logic       mosi,
  input  logic [7:0] tx_byte,
  output logic       miso,
  output logic       byte_valid,
  output logic [7:0] rx_byte,
  output logic       ssel_active
);

  logic [2:0] sck_r;      // Two sync flops plus history for edges
  logic [2:0] ssel_r;
  logic [1:0] mosi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       sel_start;  // Selection just began
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic       load_pend;  // Fetch tx_byte next cycle

  // Pin synchronizers
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_r  <= '0;
      ssel_r <= '1;  // Idle deselected
      mosi_r <= '0;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      ssel_r <= {ssel_r[1:0], ssel};
      mosi_r <= {mosi_r[0], mosi};
    end
  end

  assign sck_rise    = sck_r[1] & ~sck_r[2];
  assign sck_fall    = ~sck_r[1] & sck_r[2];
  assign ssel_active = ~ssel_r[1];           // SSEL active low
  assign sel_start   = ~ssel_r[1] & ssel_r[2];

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
      load_pend  <= 1'b0;
      tx_shift   <= '0;
    end else begin
      byte_valid <= 1'b0;
      // Assembler updates its index on byte_valid, so sample one cycle later
      load_pend  <= sel_start | byte_valid;
      if (!ssel_active) begin
        bit_cnt <= '0;  // Released, drop partial byte
      end else if (sck_rise) begin
        bit_cnt    <= bit_cnt + 3'd1;
        byte_valid <= (bit_cnt == 3'd7);  // 8th bit in
      end
      if (load_pend) begin
        tx_shift <= tx_byte;
      end else if (ssel_active && sck_fall && (bit_cnt != 3'd0)) begin
        // No shift on the 8th falling edge, next byte already in place
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

  // Receive shifter, MSB first
  always_ff @(posedge CLK) begin
    if (ssel_active && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_r[1]};
      if (bit_cnt == 3'd7) begin
        rx_byte <= {rx_shift[6:0], mosi_r[1]};
      end
    end
  end

  assign miso = tx_shift[7];

endmodule

// ==== spi_word_assembler.sv ====
`timescale 1ns/1ps

module spi_word_assembler (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           byte_valid,
  input  logic [7:0]                     rx_byte,
  input  logic                           ssel_active,
  input  logic [stepper_pkg::word_w-1:0] status,
  output logic                           word_valid,
  output logic [stepper_pkg::word_w-1:0] word,
  output logic [7:0]                     tx_byte
);

  import stepper_pkg::*;

  logic [1:0]        byte_idx;     // Byte lane, LSB first
  logic              ssel_q;       // For selection edge
  logic [word_w-1:0] status_hold;  // Status frozen for this frame

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      byte_idx    <= '0;
      word_valid  <= 1'b0;
      ssel_q      <= 1'b0;
      status_hold <= '0;
    end else begin
      ssel_q     <= ssel_active;
      word_valid <= byte_valid && (byte_idx == 2'd3);  // Fourth byte closes word
      if (!ssel_active) begin
        byte_idx <= '0;  // Partial word discarded
      end else if (byte_valid) begin
        byte_idx <= byte_idx + 2'd1;
      end
      if (ssel_active && !ssel_q) begin
        status_hold <= status;
      end
    end
  end

  // Little-endian byte placement
  always_ff @(posedge CLK) begin
    if (byte_valid) begin
      word[{byte_idx, 3'b000} +: 8] <= rx_byte;
    end
  end

  assign tx_byte = status_hold[{byte_idx, 3'b000} +: 8];  // Same lane order out

endmodule

// ==== command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder #(
  parameter int DIV_W = 24,
  parameter int DUR_W = 32
) (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           word_valid,
  input  logic [stepper_pkg::word_w-1:0] word,
  output logic                           start,
  output logic                           dir,
  output stepper_pkg::ustep_t            ustep,
  output logic [DIV_W-1:0]               divisor,
  output logic [DUR_W-1:0]               duration
);

  import stepper_pkg::*;

  logic       awaiting;  // Next word is message data
  logic [7:0] pend_op;   // Opcode owning that data

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      awaiting <= 1'b0;
      pend_op  <= '0;
      start    <= 1'b0;
      dir      <= 1'b0;
      ustep    <= ustep_full;
      divisor  <= DIV_W'(default_divisor);
      duration <= DUR_W'(default_duration);
    end else begin
      start <= 1'b0;
      if (word_valid && awaiting) begin
        awaiting <= 1'b0;
        if (pend_op == op_move) begin
          duration <= word[DUR_W-1:0];  // Move length in CLK cycles
          start    <= 1'b1;
        end
      end else if (word_valid) begin
        case (word[31:24])
          op_move: begin
            dir      <= word[0];
            awaiting <= 1'b1;
            pend_op  <= op_move;
          end
          op_divisor: begin
            if (word[DIV_W-1:0] != '0) begin  // Zero would stall the timer
              divisor <= word[DIV_W-1:0];
            end
          end
          op_microstep: begin
            // Powers of two only
            case (word[3:0])
              4'd1:    ustep <= ustep_full;
              4'd2:    ustep <= ustep_half;
              4'd4:    ustep <= ustep_quarter;
              4'd8:    ustep <= ustep_eighth;
              default: ustep <= ustep;
            endcase
          end
          default: begin
            pend_op <= '0;  // Unknown, next word is a header again
          end
        endcase
      end
    end
  end

endmodule

// ==== move_timer.sv ====
`timescale 1ns/1ps

module move_timer #(
  parameter int DIV_W = 24,
  parameter int DUR_W = 32
) (
  input  logic                           CLK,
  input  logic                           arst_n,
  input  logic                           start,
  input  logic [DIV_W-1:0]               divisor,
  input  logic [DUR_W-1:0]               duration,
  output logic                           step,
  output logic                           busy,
  output logic [stepper_pkg::word_w-1:0] step_count
);

  logic [DIV_W-1:0] div_q;    // Captured at start
  logic [DUR_W-1:0] dur_q;
  logic [DUR_W-1:0] dur_cnt;  // Busy cycle number, 1 based
  logic [DIV_W-1:0] int_cnt;  // Position inside current interval

  // Pulse on the last cycle of each interval
  assign step = busy && (int_cnt == div_q);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy       <= 1'b0;
      div_q      <= '0;
      dur_q      <= '0;
      dur_cnt    <= '0;
      int_cnt    <= '0;
      step_count <= '0;
    end else if (!busy) begin
      if (start && (duration != '0)) begin  // Moves only accepted when idle
        busy       <= 1'b1;
        div_q      <= divisor;
        dur_q      <= duration;
        dur_cnt    <= DUR_W'(1);
        int_cnt    <= DIV_W'(1);
        step_count <= '0;
      end
    end else begin
      dur_cnt <= dur_cnt + DUR_W'(1);
      if (dur_cnt == dur_q) begin
        busy <= 1'b0;  // Exactly duration cycles high
      end
      if (step) begin
        int_cnt    <= DIV_W'(1);
        step_count <= step_count + 1'b1;
      end else begin
        int_cnt <= int_cnt + DIV_W'(1);
      end
    end
  end

endmodule

// ==== dual_hbridge.sv ====
`timescale 1ns/1ps

module dual_hbridge (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                step,
  input  logic                dir,
  input  stepper_pkg::ustep_t ustep,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                pwm_a,
  output logic                pwm_b
);

  import stepper_pkg::*;

  logic [phase_idx_w-1:0] idx;        // Electrical angle
  logic [phase_idx_w-1:0] step_size;
  logic [phase_idx_w-1:0] aligned;
  logic [phase_idx_w-1:0] idx_next;
  logic [phase_idx_w-1:0] idx_b;      // Coil B leads by 90 degrees
  logic [7:0]             mag_a;
  logic [7:0]             mag_b;
  logic [7:0]             mag_a_next;
  logic [7:0]             mag_b_next;
  logic [7:0]             pwm_cnt;

  // |sin| over 32 positions, mirrored around each quarter
  function automatic logic [7:0] sine_mag(input logic [phase_idx_w-1:0] i);
    logic [3:0] m;
    m = i[3:0];
    if (m > 4'd8) begin
      m = 4'd0 - m;  // Falling half of the hump
    end
    case (m)
      4'd0:    sine_mag = 8'd0;
      4'd1:    sine_mag = 8'd50;
      4'd2:    sine_mag = 8'd98;
      4'd3:    sine_mag = 8'd142;
      4'd4:    sine_mag = 8'd180;
      4'd5:    sine_mag = 8'd212;
      4'd6:    sine_mag = 8'd236;
      4'd7:    sine_mag = 8'd250;
      default: sine_mag = 8'd255;
    endcase
  endfunction

  assign step_size  = phase_idx_w'(8 >> ustep);          // 8, 4, 2 or 1
  assign aligned    = idx & ~(step_size - 1'b1);         // Snap after ustep change
  assign idx_next   = dir ? aligned + step_size : aligned - step_size;
  assign idx_b      = idx_next + phase_idx_w'(8);
  assign mag_a_next = sine_mag(idx_next);
  assign mag_b_next = sine_mag(idx_b);

  // Outputs stay off until the first step
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      idx      <= '0;
      mag_a    <= '0;
      mag_b    <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else if (step) begin
      idx      <= idx_next;
      mag_a    <= mag_a_next;
      mag_b    <= mag_b_next;
      phase_a1 <= !idx_next[4] && (mag_a_next != 8'd0);  // Upper half negative
      phase_a2 <= idx_next[4] && (mag_a_next != 8'd0);
      phase_b1 <= !idx_b[4] && (mag_b_next != 8'd0);
      phase_b2 <= idx_b[4] && (mag_b_next != 8'd0);
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 8'd1;  // Free running
    end
  end

  assign pwm_a = (pwm_cnt < mag_a);
  assign pwm_b = (pwm_cnt < mag_b);

endmodule

// ==== stepper_spi_top.sv ====
`timescale 1ns/1ps

module stepper_spi_top #(
  parameter int DIV_W = 24,
  parameter int DUR_W = 32
) (
  input  logic CLK,
  input  logic arst_n,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic led,
  output logic step,
  output logic dir,
  output logic busy,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b
);

  import stepper_pkg::*;

  logic              byte_valid;
  logic [7:0]        rx_byte;
  logic [7:0]        tx_byte;
  logic              ssel_active;
  logic              word_valid;
  logic [word_w-1:0] word;
  logic              start;
  ustep_t            ustep;
  logic [DIV_W-1:0]  divisor;
  logic [DUR_W-1:0]  duration;
  logic [word_w-1:0] step_count;  // Status word for the host

  spi_slave i_spi_slave (
    .CLK, .arst_n, .sck, .ssel, .mosi, .tx_byte,
    .miso, .byte_valid, .rx_byte, .ssel_active
  );

  spi_word_assembler i_spi_word_assembler (
    .CLK, .arst_n, .byte_valid, .rx_byte, .ssel_active,
    .status(step_count), .word_valid, .word, .tx_byte
  );

  command_decoder #(.DIV_W(DIV_W), .DUR_W(DUR_W)) i_command_decoder (
    .CLK, .arst_n, .word_valid, .word,
    .start, .dir, .ustep, .divisor, .duration
  );

  move_timer #(.DIV_W(DIV_W), .DUR_W(DUR_W)) i_move_timer (
    .CLK, .arst_n, .start, .divisor, .duration,
    .step, .busy, .step_count
  );

  dual_hbridge i_dual_hbridge (
    .CLK, .arst_n, .step, .dir, .ustep,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2, .pwm_a, .pwm_b
  );

  // Activity LED, flips per received word
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      led <= 1'b0;
    end else if (word_valid) begin
      led <= ~led;
    end
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 10,  // 20 ns period
  parameter int reset_cycles = 5
) (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  // Release lands on a falling edge, like every other input
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
  end

endmodule

// ==== stepper_assert.sv ====
`timescale 1ns/1ps

module stepper_assert (
  input logic CLK,
  input logic arst_n,
  input logic ssel,
  input logic miso,
  input logic step,
  input logic busy,
  input logic phase_a1,
  input logic phase_a2,
  input logic phase_b1,
  input logic phase_b2
);

  int fail_cnt = 0;  // Failed assertion tally

  // Shoot-through guard on both bridges
  coil_a_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(phase_a1 && phase_a2))
    else begin
      $error("Coil A driven high on both sides");
      fail_cnt++;
    end

  coil_b_excl: assert property (@(posedge CLK) disable iff (!arst_n)
    !(phase_b1 && phase_b2))
    else begin
      $error("Coil B driven high on both sides");
      fail_cnt++;
    end

  step_in_move: assert property (@(posedge CLK) disable iff (!arst_n)
    step |-> busy)
    else begin
      $error("Step pulse outside a move");
      fail_cnt++;
    end

  step_single: assert property (@(posedge CLK) disable iff (!arst_n)
    step |=> !step)
    else begin
      $error("Step pulse longer than one cycle");
      fail_cnt++;
    end

  // Deselected slave keeps miso quiet
  miso_quiet: assert property (@(posedge CLK) disable iff (!arst_n)
    ssel && $past(ssel) |-> $stable(miso))
    else begin
      $error("MISO changed while SSEL high");
      fail_cnt++;
    end

endmodule

bind stepper_spi_top stepper_assert i_stepper_assert (
  .CLK, .arst_n, .ssel, .miso, .step, .busy,
  .phase_a1, .phase_a2, .phase_b1, .phase_b2
);

// ==== stepper_tb.sv ====
`timescale 1ns/1ps

module stepper_tb;

  import stepper_pkg::*;

  localparam int move_timeout = 12000;  // CLK cycles per wait
  localparam int reset_timeout = 20;

  logic        CLK;
  logic        arst_n;
  logic        sck;
  logic        ssel;
  logic        mosi;
  logic        miso;
  logic        led;
  logic        step;
  logic        dir;
  logic        busy;
  logic        phase_a1;
  logic        phase_a2;
  logic        phase_b1;
  logic        phase_b2;
  logic        pwm_a;
  logic        pwm_b;
  logic [3:0]  coils;          // Polarity pattern
  logic [9:0]  out_vec;        // Everything that must reset low
  integer      seed = 32'had6a;
  int          errors = 0;
  int          moves_done = 0;  // Completed busy periods
  int          run_cycles = 0;
  int          run_steps = 0;
  int          last_cycles = 0;
  int          last_steps = 0;
  logic        in_move = 1'b0;
  logic [31:0] status_rx;      // Word shifted back on miso

  assign coils   = {phase_a1, phase_a2, phase_b1, phase_b2};
  assign out_vec = {step, busy, led, coils, pwm_a, pwm_b, miso};

  tb_clock_gen i_tb_clock_gen (.CLK, .arst_n);

  stepper_spi_top i_stepper_spi_top (
    .CLK, .arst_n, .sck, .ssel, .mosi, .miso, .led, .step, .dir, .busy,
    .phase_a1, .phase_a2, .phase_b1, .phase_b2, .pwm_a, .pwm_b
  );

  // Busy period monitor sampled mid-cycle
  always @(negedge CLK) begin
    if (arst_n && busy) begin
      if (!in_move) begin
        run_cycles = 0;
        run_steps  = 0;
      end
      in_move = 1'b1;
      run_cycles++;
      run_steps += int'(step);
    end else if (in_move) begin
      in_move     = 1'b0;  // Falling busy closes the move
      last_cycles = run_cycles;
      last_steps  = run_steps;
      moves_done++;
    end
  end

  function automatic int bound_failures();
    return i_stepper_spi_top.i_stepper_assert.fail_cnt;
  endfunction

  task automatic expect_value(input string what, input int got, input int exp);
    assert (got == exp) else begin
      errors++;
      $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Closing: %0d check errors, %0d assertion failures",
             errors, bound_failures());
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic wait_moves(input int target);
    int n;
    n = 0;
    while (moves_done < target && n < move_timeout) begin
      @(negedge CLK);
      n++;
    end
    if (moves_done < target) abort_run("the end of a move");
  endtask

  // PWM activity over one counter period against coil drive
  task automatic check_pwm();
    int i;
    int high_a;
    int high_b;
    high_a = 0;
    high_b = 0;
    for (i = 0; i < 256; i++) begin
      @(negedge CLK);
      high_a += int'(pwm_a);
      high_b += int'(pwm_b);
    end
    expect_value("pwm_a active", int'(high_a > 0), int'(phase_a1 | phase_a2));
    expect_value("pwm_b active", int'(high_b > 0), int'(phase_b1 | phase_b2));
  endtask

  // Mode 0 byte with SCK at CLK/16
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    int i;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (8) @(negedge CLK);
      rx[i] = miso;  // Slave shifted on the previous fall
      sck   = 1'b1;
      repeat (8) @(negedge CLK);
      sck = 1'b0;
    end
  endtask

  // One message per selection with words little-endian
  task automatic send_frame(input logic [31:0] w0, input logic [31:0] w1,
                            input int nbytes);
    logic [63:0] data;
    logic [7:0]  rx;
    int          b;
    data = {w1, w0};
    ssel = 1'b0;
    repeat (4) @(negedge CLK);
    for (b = 0; b < nbytes; b++) begin
      spi_byte(data[8*b +: 8], rx);
      if (b < 4) status_rx[8*b +: 8] = rx;
    end
    repeat (4) @(negedge CLK);
    ssel = 1'b1;
    repeat (8) @(negedge CLK);  // Let the byte index clear
  endtask

  task automatic run_move(input logic d, input int dur);
    int target;
    target = moves_done + 1;
    send_frame({op_move, 23'd0, d}, 32'(dur), 8);
    wait_moves(target);
  endtask

  initial begin
    int         n;
    int         div;
    int         dur;
    int         expect_status;
    logic       d;
    logic       led_q;
    logic [3:0] start_pat;
    logic [3:0] prev_pat;
    sck           = 1'b0;
    ssel          = 1'b1;
    mosi          = 1'b0;
    expect_status = 0;  // Nothing moved yet

    @(negedge CLK);
    expect_value("outputs in reset", int'(out_vec), 0);
    n = 0;
    while (!arst_n && n < reset_timeout) begin
      @(posedge CLK);
      n++;
    end
    if (!arst_n) abort_run("reset release");
    @(negedge CLK);
    expect_value("outputs after reset", int'(out_vec), 0);

    // Random moves with each status read during the next frame
    repeat (6) begin
      div = 5 + int'($unsigned($random(seed)) % 196);
      dur = 100 + int'($unsigned($random(seed)) % 3900);
      d   = 1'($random(seed));
      send_frame({op_divisor, 24'(div)}, 32'd0, 4);
      expect_value("status word", int'(status_rx), expect_status);
      run_move(d, dur);
      expect_value("busy cycles", last_cycles, dur);
      expect_value("step pulses", last_steps, dur / div);
      expect_value("dir", int'(dir), int'(d));
      expect_status = dur / div;
    end

    // Bad commands keep divisor 10
    send_frame({op_divisor, 24'd10}, 32'd0, 4);
    send_frame({op_divisor, 24'd0}, 32'd0, 4);
    send_frame(32'h7e00_0033, 32'd0, 4);  // Unknown opcode
    run_move(1'b1, 1005);
    expect_value("steps after bad commands", last_steps, 100);

    n = moves_done;
    send_frame({op_move, 24'd1}, 32'd3000, 8);
    send_frame({op_move, 24'd0}, 32'd500, 8);  // Arrives mid move
    wait_moves(n + 1);
    expect_value("busy cycles with second move", last_cycles, 3000);
    repeat (100) @(negedge CLK);
    expect_value("moves after dropped command", moves_done, n + 1);

    // Full step stays after invalid code 3
    send_frame({op_microstep, 24'd1}, 32'd0, 4);
    send_frame({op_microstep, 24'd3}, 32'd0, 4);
    start_pat = coils;
    prev_pat  = coils;
    repeat (4) begin
      run_move(1'b1, 15);  // One step at divisor 10
      expect_value("full step changes coils", int'(coils != prev_pat), 1);
      check_pwm();
      prev_pat = coils;
    end
    expect_value("coils after 4 full steps", int'(coils), int'(start_pat));

    // Count single eighth steps until the start pattern is back
    send_frame({op_microstep, 24'd8}, 32'd0, 4);
    run_move(1'b1, 15);
    n = 1;
    while (coils != start_pat && n < 40) begin
      run_move(1'b1, 15);
      n++;
    end
    expect_value("eighth steps to return", n, 32);

    send_frame({op_microstep, 24'd4}, 32'd0, 4);
    run_move(1'b1, 55);   // 5 quarter steps up
    run_move(1'b0, 55);   // and back
    expect_value("coils after up and down", int'(coils), int'(start_pat));

    // LED toggles per full word only
    led_q = led;
    send_frame({op_divisor, 24'd20}, 32'd0, 2);  // Cut after two bytes
    expect_value("led after cut frame", int'(led), int'(led_q));
    send_frame({op_divisor, 24'd20}, 32'd0, 4);
    expect_value("led after one word", int'(led), int'(!led_q));
    run_move(1'b0, 205);
    expect_value("steps at divisor 20", last_steps, 10);

    $display("Closing: %0d check errors, %0d assertion failures",
             errors, bound_failures());
    if (errors == 0 && bound_failures() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
stepper_pkg.sv
spi_slave.sv
spi_word_assembler.sv
command_decoder.sv
move_timer.sv
dual_hbridge.sv
stepper_spi_top.sv
tb_clock_gen.sv
stepper_assert.sv
stepper_tb.sv

// ==== Bender.yml ====
package:
  name: stepper_spi

sources:
  - stepper_pkg.sv
  - spi_slave.sv
  - spi_word_assembler.sv
  - command_decoder.sv
  - move_timer.sv
  - dual_hbridge.sv
  - stepper_spi_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - stepper_assert.sv
      - stepper_tb.sv
